/* rtl/cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

	// rob tag and result word carried on either bus
	localparam int TAG_WIDTH = 6;
	localparam int WORD_WIDTH = 32;

	// read ports per register class
	localparam int N_READ = 2;

	// single-cycle requesters, index 0 wins
	// gpr: glw, alu, mov
	localparam int GPR_N_SINGLE = 3;
	// fpr: flw, fmov
	localparam int FPR_N_SINGLE = 2;

endpackage

`default_nettype wire

/* rtl/slot_delay.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_delay #(
	parameter int LEN = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] in_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] in_data,
	output logic out_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] out_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] out_data
);
	import cdb_pkg::*;

	logic valid_q [LEN];
	logic [TAG_WIDTH-1:0] tag_q [LEN];
	logic [WORD_WIDTH-1:0] data_q [LEN];

	// head requester is never refused
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LEN; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < LEN; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		tag_q[0] <= in_tag;
		data_q[0] <= in_data;
		for (int i = 1; i < LEN; i++) begin
			tag_q[i] <= tag_q[i-1];
			data_q[i] <= data_q[i-1];
		end
	end

	assign out_valid = valid_q[LEN-1];
	assign out_tag = tag_q[LEN-1];
	assign out_data = data_q[LEN-1];

endmodule

`default_nettype wire

/* rtl/slot_segment.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_segment #(
	parameter int LEN = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic up_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] up_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] up_data,
	input  logic local_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] local_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] local_data,
	output logic local_ready,
	output logic out_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] out_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] out_data
);
	import cdb_pkg::*;

	logic valid_q [LEN];
	logic [TAG_WIDTH-1:0] tag_q [LEN];
	logic [WORD_WIDTH-1:0] data_q [LEN];

	// slot already taken by a longer-latency booking
	assign local_ready = !up_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LEN; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= up_valid || (local_valid && local_ready);
			for (int i = 1; i < LEN; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// upstream booking wins the entry stage
	always_ff @(posedge clk) begin
		tag_q[0] <= up_valid ? up_tag : local_tag;
		data_q[0] <= up_valid ? up_data : local_data;
		for (int i = 1; i < LEN; i++) begin
			tag_q[i] <= tag_q[i-1];
			data_q[i] <= data_q[i-1];
		end
	end

	assign out_valid = valid_q[LEN-1];
	assign out_tag = tag_q[LEN-1];
	assign out_data = data_q[LEN-1];

endmodule

`default_nettype wire

/* rtl/cdb_drive.sv */
`timescale 1ns/1ns
`default_nettype none

module cdb_drive #(
	parameter int N_SINGLE = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic up_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] up_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] up_data,
	input  logic [N_SINGLE-1:0] single_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] single_tag [N_SINGLE],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] single_data [N_SINGLE],
	output logic [N_SINGLE-1:0] single_ready,
	input  logic zero_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] zero_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] zero_data,
	output logic zero_ready,
	output logic cdb_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] cdb_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] cdb_data
);
	import cdb_pkg::*;

	logic blocked;
	logic sel_valid;
	logic [TAG_WIDTH-1:0] sel_tag;
	logic [WORD_WIDTH-1:0] sel_data;
	logic final_valid;
	logic [TAG_WIDTH-1:0] final_tag;
	logic [WORD_WIDTH-1:0] final_data;

	//////////////////////////////
	// single-cycle arbitration
	//////////////////////////////

	// lowest index first, all refused under an upstream booking
	always_comb begin
		blocked = up_valid;
		sel_valid = 1'b0;
		sel_tag = single_tag[0];
		sel_data = single_data[0];
		for (int i = 0; i < N_SINGLE; i++) begin
			single_ready[i] = !blocked;
			if (single_valid[i] && !blocked) begin
				sel_valid = 1'b1;
				sel_tag = single_tag[i];
				sel_data = single_data[i];
			end
			blocked = blocked || single_valid[i];
		end
	end

	//////////////////////////////
	// final stage and bus
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			final_valid <= 1'b0;
		end else begin
			final_valid <= up_valid || sel_valid;
		end
	end

	always_ff @(posedge clk) begin
		final_tag <= up_valid ? up_tag : sel_tag;
		final_data <= up_valid ? up_data : sel_data;
	end

	// zero-latency result only fills an empty slot
	assign zero_ready = !final_valid;

	assign cdb_valid = final_valid || zero_valid;
	assign cdb_tag = final_valid ? final_tag : zero_tag;
	assign cdb_data = final_valid ? final_data : zero_data;

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
	input  logic [cdb_pkg::N_READ-1:0] arch_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] arch_tag [cdb_pkg::N_READ],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] arch_data [cdb_pkg::N_READ],
	input  logic [cdb_pkg::N_READ-1:0] rob_valid,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] rob_data [cdb_pkg::N_READ],
	input  logic cdb_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] cdb_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] cdb_data,
	output logic [cdb_pkg::N_READ-1:0] read_valid,
	output logic [cdb_pkg::WORD_WIDTH-1:0] read_data [cdb_pkg::N_READ]
);
	import cdb_pkg::*;

	logic [N_READ-1:0] hit;

	for (genvar i = 0; i < N_READ; i++) begin : g_port
		// result broadcast this cycle for the renamed tag
		assign hit[i] = cdb_valid && cdb_tag == arch_tag[i];

		assign read_valid[i] = arch_valid[i] || hit[i] || rob_valid[i];
		assign read_data[i] = arch_valid[i] ? arch_data[i] :
		                      hit[i] ? cdb_data : rob_data[i];
	end

endmodule

`default_nettype wire

/* rtl/fpr_wb_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module fpr_wb_bus #(
	parameter int FDIV_LATENCY = 14,
	parameter int FADD_LATENCY = 6,
	parameter int FMUL_LATENCY = 4,
	parameter int ITOF_LATENCY = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic fdiv_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fdiv_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fdiv_data,
	input  logic fadd_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fadd_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fadd_data,
	output logic fadd_ready,
	input  logic fmul_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fmul_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fmul_data,
	output logic fmul_ready,
	input  logic itof_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] itof_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] itof_data,
	output logic itof_ready,
	input  logic [cdb_pkg::FPR_N_SINGLE-1:0] fpr_single_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fpr_single_tag [cdb_pkg::FPR_N_SINGLE],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fpr_single_data [cdb_pkg::FPR_N_SINGLE],
	output logic [cdb_pkg::FPR_N_SINGLE-1:0] fpr_single_ready,
	input  logic fin_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fin_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fin_data,
	output logic fin_ready,
	output logic fpr_cdb_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] fpr_cdb_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] fpr_cdb_data
);
	import cdb_pkg::*;

	// stage counts between entry points
	localparam int DIV_LEN = FDIV_LATENCY - FADD_LATENCY;
	localparam int ADD_LEN = FADD_LATENCY - FMUL_LATENCY;
	localparam int MUL_LEN = FMUL_LATENCY - ITOF_LATENCY;
	localparam int ITOF_LEN = ITOF_LATENCY - 1;

	logic div_valid;
	logic [TAG_WIDTH-1:0] div_tag;
	logic [WORD_WIDTH-1:0] div_data;
	logic add_valid;
	logic [TAG_WIDTH-1:0] add_tag;
	logic [WORD_WIDTH-1:0] add_data;
	logic mul_valid;
	logic [TAG_WIDTH-1:0] mul_tag;
	logic [WORD_WIDTH-1:0] mul_data;
	logic cvt_valid;
	logic [TAG_WIDTH-1:0] cvt_tag;
	logic [WORD_WIDTH-1:0] cvt_data;

	slot_delay #(.LEN(DIV_LEN)) div_chain (
		.clk, .rst,
		.in_valid(fdiv_valid), .in_tag(fdiv_tag), .in_data(fdiv_data),
		.out_valid(div_valid), .out_tag(div_tag), .out_data(div_data)
	);

	slot_segment #(.LEN(ADD_LEN)) add_seg (
		.clk, .rst,
		.up_valid(div_valid), .up_tag(div_tag), .up_data(div_data),
		.local_valid(fadd_valid), .local_tag(fadd_tag), .local_data(fadd_data),
		.local_ready(fadd_ready),
		.out_valid(add_valid), .out_tag(add_tag), .out_data(add_data)
	);

	slot_segment #(.LEN(MUL_LEN)) mul_seg (
		.clk, .rst,
		.up_valid(add_valid), .up_tag(add_tag), .up_data(add_data),
		.local_valid(fmul_valid), .local_tag(fmul_tag), .local_data(fmul_data),
		.local_ready(fmul_ready),
		.out_valid(mul_valid), .out_tag(mul_tag), .out_data(mul_data)
	);

	slot_segment #(.LEN(ITOF_LEN)) itof_seg (
		.clk, .rst,
		.up_valid(mul_valid), .up_tag(mul_tag), .up_data(mul_data),
		.local_valid(itof_valid), .local_tag(itof_tag), .local_data(itof_data),
		.local_ready(itof_ready),
		.out_valid(cvt_valid), .out_tag(cvt_tag), .out_data(cvt_data)
	);

	// flw ahead of fmov, fin fills empty cycles
	cdb_drive #(.N_SINGLE(FPR_N_SINGLE)) drive (
		.clk, .rst,
		.up_valid(cvt_valid), .up_tag(cvt_tag), .up_data(cvt_data),
		.single_valid(fpr_single_valid), .single_tag(fpr_single_tag),
		.single_data(fpr_single_data), .single_ready(fpr_single_ready),
		.zero_valid(fin_valid), .zero_tag(fin_tag), .zero_data(fin_data),
		.zero_ready(fin_ready),
		.cdb_valid(fpr_cdb_valid), .cdb_tag(fpr_cdb_tag), .cdb_data(fpr_cdb_data)
	);

endmodule

`default_nettype wire

/* rtl/gpr_wb_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module gpr_wb_bus #(
	parameter int FTOI_LATENCY = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic ftoi_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] ftoi_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] ftoi_data,
	input  logic [cdb_pkg::GPR_N_SINGLE-1:0] gpr_single_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] gpr_single_tag [cdb_pkg::GPR_N_SINGLE],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gpr_single_data [cdb_pkg::GPR_N_SINGLE],
	output logic [cdb_pkg::GPR_N_SINGLE-1:0] gpr_single_ready,
	input  logic gin_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] gin_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gin_data,
	output logic gin_ready,
	output logic gpr_cdb_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] gpr_cdb_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] gpr_cdb_data
);
	import cdb_pkg::*;

	// last stage lives in the drive block
	localparam int FTOI_LEN = FTOI_LATENCY - 1;

	logic cvt_valid;
	logic [TAG_WIDTH-1:0] cvt_tag;
	logic [WORD_WIDTH-1:0] cvt_data;

	slot_delay #(.LEN(FTOI_LEN)) ftoi_chain (
		.clk, .rst,
		.in_valid(ftoi_valid), .in_tag(ftoi_tag), .in_data(ftoi_data),
		.out_valid(cvt_valid), .out_tag(cvt_tag), .out_data(cvt_data)
	);

	// glw, alu, mov in that order, gin fills empty cycles
	cdb_drive #(.N_SINGLE(GPR_N_SINGLE)) drive (
		.clk, .rst,
		.up_valid(cvt_valid), .up_tag(cvt_tag), .up_data(cvt_data),
		.single_valid(gpr_single_valid), .single_tag(gpr_single_tag),
		.single_data(gpr_single_data), .single_ready(gpr_single_ready),
		.zero_valid(gin_valid), .zero_tag(gin_tag), .zero_data(gin_data),
		.zero_ready(gin_ready),
		.cdb_valid(gpr_cdb_valid), .cdb_tag(gpr_cdb_tag), .cdb_data(gpr_cdb_data)
	);

endmodule

`default_nettype wire

/* rtl/result_broadcast.sv */
`timescale 1ns/1ns
`default_nettype none

module result_broadcast #(
	parameter int FDIV_LATENCY = 14,
	parameter int FADD_LATENCY = 6,
	parameter int FMUL_LATENCY = 4,
	parameter int ITOF_LATENCY = 3,
	parameter int FTOI_LATENCY = 3
) (
	input  logic clk,
	input  logic rst,
	// fpr requesters
	input  logic fdiv_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fdiv_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fdiv_data,
	input  logic fadd_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fadd_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fadd_data,
	output logic fadd_ready,
	input  logic fmul_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fmul_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fmul_data,
	output logic fmul_ready,
	input  logic itof_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] itof_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] itof_data,
	output logic itof_ready,
	input  logic [cdb_pkg::FPR_N_SINGLE-1:0] fpr_single_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fpr_single_tag [cdb_pkg::FPR_N_SINGLE],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fpr_single_data [cdb_pkg::FPR_N_SINGLE],
	output logic [cdb_pkg::FPR_N_SINGLE-1:0] fpr_single_ready,
	input  logic fin_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fin_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fin_data,
	output logic fin_ready,
	output logic fpr_cdb_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] fpr_cdb_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] fpr_cdb_data,
	// gpr requesters
	input  logic ftoi_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] ftoi_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] ftoi_data,
	input  logic [cdb_pkg::GPR_N_SINGLE-1:0] gpr_single_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] gpr_single_tag [cdb_pkg::GPR_N_SINGLE],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gpr_single_data [cdb_pkg::GPR_N_SINGLE],
	output logic [cdb_pkg::GPR_N_SINGLE-1:0] gpr_single_ready,
	input  logic gin_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] gin_tag,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gin_data,
	output logic gin_ready,
	output logic gpr_cdb_valid,
	output logic [cdb_pkg::TAG_WIDTH-1:0] gpr_cdb_tag,
	output logic [cdb_pkg::WORD_WIDTH-1:0] gpr_cdb_data,
	// read ports
	input  logic [cdb_pkg::N_READ-1:0] fpr_arch_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] fpr_arch_tag [cdb_pkg::N_READ],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fpr_arch_data [cdb_pkg::N_READ],
	input  logic [cdb_pkg::N_READ-1:0] fpr_rob_valid,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] fpr_rob_data [cdb_pkg::N_READ],
	output logic [cdb_pkg::N_READ-1:0] fpr_read_valid,
	output logic [cdb_pkg::WORD_WIDTH-1:0] fpr_read_data [cdb_pkg::N_READ],
	input  logic [cdb_pkg::N_READ-1:0] gpr_arch_valid,
	input  logic [cdb_pkg::TAG_WIDTH-1:0] gpr_arch_tag [cdb_pkg::N_READ],
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gpr_arch_data [cdb_pkg::N_READ],
	input  logic [cdb_pkg::N_READ-1:0] gpr_rob_valid,
	input  logic [cdb_pkg::WORD_WIDTH-1:0] gpr_rob_data [cdb_pkg::N_READ],
	output logic [cdb_pkg::N_READ-1:0] gpr_read_valid,
	output logic [cdb_pkg::WORD_WIDTH-1:0] gpr_read_data [cdb_pkg::N_READ]
);

	//////////////////////////////
	// buses
	//////////////////////////////

	fpr_wb_bus #(
		.FDIV_LATENCY(FDIV_LATENCY),
		.FADD_LATENCY(FADD_LATENCY),
		.FMUL_LATENCY(FMUL_LATENCY),
		.ITOF_LATENCY(ITOF_LATENCY)
	) fpr_bus (
		.clk, .rst,
		.fdiv_valid, .fdiv_tag, .fdiv_data,
		.fadd_valid, .fadd_tag, .fadd_data, .fadd_ready,
		.fmul_valid, .fmul_tag, .fmul_data, .fmul_ready,
		.itof_valid, .itof_tag, .itof_data, .itof_ready,
		.fpr_single_valid, .fpr_single_tag, .fpr_single_data, .fpr_single_ready,
		.fin_valid, .fin_tag, .fin_data, .fin_ready,
		.fpr_cdb_valid, .fpr_cdb_tag, .fpr_cdb_data
	);

	gpr_wb_bus #(.FTOI_LATENCY(FTOI_LATENCY)) gpr_bus (
		.clk, .rst,
		.ftoi_valid, .ftoi_tag, .ftoi_data,
		.gpr_single_valid, .gpr_single_tag, .gpr_single_data, .gpr_single_ready,
		.gin_valid, .gin_tag, .gin_data, .gin_ready,
		.gpr_cdb_valid, .gpr_cdb_tag, .gpr_cdb_data
	);

	//////////////////////////////
	// operand reads
	//////////////////////////////

	operand_bypass fpr_bypass (
		.arch_valid(fpr_arch_valid), .arch_tag(fpr_arch_tag), .arch_data(fpr_arch_data),
		.rob_valid(fpr_rob_valid), .rob_data(fpr_rob_data),
		.cdb_valid(fpr_cdb_valid), .cdb_tag(fpr_cdb_tag), .cdb_data(fpr_cdb_data),
		.read_valid(fpr_read_valid), .read_data(fpr_read_data)
	);

	operand_bypass gpr_bypass (
		.arch_valid(gpr_arch_valid), .arch_tag(gpr_arch_tag), .arch_data(gpr_arch_data),
		.rob_valid(gpr_rob_valid), .rob_data(gpr_rob_data),
		.cdb_valid(gpr_cdb_valid), .cdb_tag(gpr_cdb_tag), .cdb_data(gpr_cdb_data),
		.read_valid(gpr_read_valid), .read_data(gpr_read_data)
	);

endmodule

`default_nettype wire

/* sim/tb_result_broadcast.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_result_broadcast;
	import cdb_pkg::*;

	localparam int FDIV_LATENCY = 14;
	localparam int FADD_LATENCY = 6;
	localparam int FMUL_LATENCY = 4;
	localparam int ITOF_LATENCY = 3;
	localparam int FTOI_LATENCY = 3;
	// requester index order fdiv fadd fmul itof flw fmov fin then ftoi glw alu mov gin
	localparam int NREQ = 12;
	localparam int FIRST_GPR = 7;
	localparam int CAL = 32;
	localparam int N_ROWS = 26;
	localparam int N_RANDOM = 200;
	localparam int LIMIT = N_ROWS + N_RANDOM + FDIV_LATENCY + 50;

	logic clk, rst;
	logic fdiv_valid, fadd_valid, fmul_valid, itof_valid, fin_valid, ftoi_valid, gin_valid;
	logic fadd_ready, fmul_ready, itof_ready, fin_ready, gin_ready;
	logic [TAG_WIDTH-1:0] fdiv_tag, fadd_tag, fmul_tag, itof_tag, fin_tag, ftoi_tag, gin_tag;
	logic [WORD_WIDTH-1:0] fdiv_data, fadd_data, fmul_data, itof_data;
	logic [WORD_WIDTH-1:0] fin_data, ftoi_data, gin_data;
	logic [FPR_N_SINGLE-1:0] fpr_single_valid, fpr_single_ready;
	logic [TAG_WIDTH-1:0] fpr_single_tag [FPR_N_SINGLE];
	logic [WORD_WIDTH-1:0] fpr_single_data [FPR_N_SINGLE];
	logic [GPR_N_SINGLE-1:0] gpr_single_valid, gpr_single_ready;
	logic [TAG_WIDTH-1:0] gpr_single_tag [GPR_N_SINGLE];
	logic [WORD_WIDTH-1:0] gpr_single_data [GPR_N_SINGLE];
	logic fpr_cdb_valid, gpr_cdb_valid;
	logic [TAG_WIDTH-1:0] fpr_cdb_tag, gpr_cdb_tag;
	logic [WORD_WIDTH-1:0] fpr_cdb_data, gpr_cdb_data;
	logic [N_READ-1:0] fpr_arch_valid, fpr_rob_valid, fpr_read_valid;
	logic [N_READ-1:0] gpr_arch_valid, gpr_rob_valid, gpr_read_valid;
	logic [TAG_WIDTH-1:0] fpr_arch_tag [N_READ], gpr_arch_tag [N_READ];
	logic [WORD_WIDTH-1:0] fpr_arch_data [N_READ], fpr_rob_data [N_READ], fpr_read_data [N_READ];
	logic [WORD_WIDTH-1:0] gpr_arch_data [N_READ], gpr_rob_data [N_READ], gpr_read_data [N_READ];

	// booking calendar per class indexed by broadcast cycle
	logic cal_v [2][CAL];
	logic [TAG_WIDTH-1:0] cal_t [2][CAL];
	logic [WORD_WIDTH-1:0] cal_d [2][CAL];
	logic [NREQ-1:0] req_v, acc, exp_rdy;
	logic [NREQ-1:0][TAG_WIDTH-1:0] req_t;
	logic [NREQ-1:0][WORD_WIDTH-1:0] req_d;
	logic exp_v [2];
	logic [TAG_WIDTH-1:0] exp_t [2];
	logic [WORD_WIDTH-1:0] exp_d [2];
	logic [N_READ-1:0] rd_av [2], rd_rv [2];
	logic [TAG_WIDTH-1:0] rd_at [2][N_READ];
	logic [WORD_WIDTH-1:0] rd_ad [2][N_READ], rd_rd [2][N_READ];
	int lat [NREQ] = '{FDIV_LATENCY, FADD_LATENCY, FMUL_LATENCY, ITOF_LATENCY, 1, 1, 0,
		FTOI_LATENCY, 1, 1, 1, 0};
	string req_name [NREQ] = '{"fdiv_accept", "fadd_ready", "fmul_ready", "itof_ready",
		"fpr_single_ready[0]", "fpr_single_ready[1]", "fin_ready", "ftoi_accept",
		"gpr_single_ready[0]", "gpr_single_ready[1]", "gpr_single_ready[2]", "gin_ready"};
	integer seed = 32'hd4a5_dfde;
	int n, max_flight, cycles;

	// row is {gpr reads, fpr reads, request mask}
	// each read field is {match[1:0], rob[1:0], arch[1:0]}
	logic [23:0] stim [N_ROWS] = '{
		{6'b000000, 6'b000000, 12'h000}, {6'b000000, 6'b000000, 12'h000},
		// each requester alone with broadcasts spread out
		{6'b100100, 6'b110001, 12'h840}, {6'b000000, 6'b000000, 12'h420},
		{6'b001100, 6'b011000, 12'h210}, {6'b000000, 6'b000000, 12'h108},
		{6'b000000, 6'b000000, 12'h084}, {6'b000000, 6'b000000, 12'h002},
		{6'b000000, 6'b000000, 12'h001},
		// single-cycle priority and zero-latency against a held slot
		{6'b000000, 6'b000000, 12'h730}, {6'b000000, 6'b000000, 12'h730},
		{6'b000000, 6'b000000, 12'h620}, {6'b000000, 6'b000000, 12'h840},
		{6'b000000, 6'b000000, 12'h840}, {6'b000000, 6'b000000, 12'h000},
		{6'b000000, 6'b000000, 12'h000},
		// fadd into a slot fdiv already holds
		{6'b000000, 6'b000000, 12'h003}, {6'b000000, 6'b000000, 12'h004},
		{6'b000000, 6'b000000, 12'h088}, {6'b000000, 6'b000000, 12'h410},
		{6'b000000, 6'b000000, 12'h110}, {6'b000000, 6'b000000, 12'h840},
		{6'b000000, 6'b111110, 12'h000}, {6'b000011, 6'b110000, 12'h000},
		{6'b000000, 6'b000000, 12'h002}, {6'b000000, 6'b000000, 12'h000}
	};

	result_broadcast #(
		.FDIV_LATENCY(FDIV_LATENCY),
		.FADD_LATENCY(FADD_LATENCY),
		.FMUL_LATENCY(FMUL_LATENCY),
		.ITOF_LATENCY(ITOF_LATENCY),
		.FTOI_LATENCY(FTOI_LATENCY)
	) dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	task automatic predict();
		int s;
		int z;
		logic blk;
		s = n % CAL;
		for (int r = 0; r < NREQ; r++) begin
			blk = 1'b0;
			// lower index wins within the same class and latency
			for (int q = 0; q < r; q++) begin
				if ((q >= FIRST_GPR) == (r >= FIRST_GPR) && lat[q] == lat[r] && req_v[q])
					blk = 1'b1;
			end
			exp_rdy[r] = !cal_v[r >= FIRST_GPR][(n + lat[r]) % CAL] && !blk;
			acc[r] = req_v[r] && exp_rdy[r];
		end
		for (int c = 0; c < 2; c++) begin
			z = c ? 11 : 6;
			exp_v[c] = cal_v[c][s] || req_v[z];
			exp_t[c] = cal_v[c][s] ? cal_t[c][s] : req_t[z];
			exp_d[c] = cal_v[c][s] ? cal_d[c][s] : req_d[z];
		end
	endtask

	task automatic commit();
		int slot;
		int c;
		int busy;
		cal_v[0][n % CAL] = 1'b0;
		cal_v[1][n % CAL] = 1'b0;
		for (int r = 0; r < NREQ; r++) begin
			if (acc[r] && lat[r] > 0) begin
				slot = (n + lat[r]) % CAL;
				c = (r >= FIRST_GPR);
				cal_v[c][slot] = 1'b1;
				cal_t[c][slot] = req_t[r];
				cal_d[c][slot] = req_d[r];
			end
		end
		busy = 0;
		for (int k = 0; k < CAL; k++)
			busy += int'(cal_v[0][k]) + int'(cal_v[1][k]);
		if (busy > max_flight)
			max_flight = busy;
		n++;
	endtask

	//////////////////////////////
	// stimulus and checks
	//////////////////////////////

	task automatic apply_row(input logic [23:0] row);
		for (int r = 0; r < NREQ; r++) begin
			req_v[r] = row[r];
			req_t[r] = TAG_WIDTH'($random(seed));
			req_d[r] = $random(seed);
		end
		predict();
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < N_READ; i++) begin
				rd_av[c][i] = row[12 + 6 * c + i];
				rd_rv[c][i] = row[14 + 6 * c + i];
				rd_at[c][i] = row[16 + 6 * c + i] ? exp_t[c] : TAG_WIDTH'($random(seed));
				rd_ad[c][i] = $random(seed);
				rd_rd[c][i] = $random(seed);
			end
		end
		{gin_valid, gpr_single_valid, ftoi_valid, fin_valid, fpr_single_valid,
			itof_valid, fmul_valid, fadd_valid, fdiv_valid} <= req_v;
		{gin_tag, gpr_single_tag[2], gpr_single_tag[1], gpr_single_tag[0], ftoi_tag, fin_tag,
			fpr_single_tag[1], fpr_single_tag[0], itof_tag, fmul_tag, fadd_tag, fdiv_tag} <= req_t;
		{gin_data, gpr_single_data[2], gpr_single_data[1], gpr_single_data[0], ftoi_data,
			fin_data, fpr_single_data[1], fpr_single_data[0], itof_data, fmul_data, fadd_data,
			fdiv_data} <= req_d;
		fpr_arch_valid <= rd_av[0];
		fpr_rob_valid <= rd_rv[0];
		gpr_arch_valid <= rd_av[1];
		gpr_rob_valid <= rd_rv[1];
		for (int i = 0; i < N_READ; i++) begin
			fpr_arch_tag[i] <= rd_at[0][i];
			fpr_arch_data[i] <= rd_ad[0][i];
			fpr_rob_data[i] <= rd_rd[0][i];
			gpr_arch_tag[i] <= rd_at[1][i];
			gpr_arch_data[i] <= rd_ad[1][i];
			gpr_rob_data[i] <= rd_rd[1][i];
		end
	endtask

	task automatic report_mismatch(input string name, input logic [WORD_WIDTH-1:0] got,
			input logic [WORD_WIDTH-1:0] exp);
		$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_bus(input string name, input logic got_v,
			input logic [TAG_WIDTH-1:0] got_t, input logic [WORD_WIDTH-1:0] got_d,
			input logic exp_v, input logic [TAG_WIDTH-1:0] exp_t,
			input logic [WORD_WIDTH-1:0] exp_d);
		if (got_v !== exp_v)
			report_mismatch({name, "_valid"}, got_v, exp_v);
		else if (exp_v && got_t !== exp_t)
			report_mismatch({name, "_tag"}, got_t, exp_t);
		else if (exp_v && got_d !== exp_d)
			report_mismatch({name, "_data"}, got_d, exp_d);
	endtask

	task automatic check_read(input string name, input logic got_v,
			input logic [WORD_WIDTH-1:0] got_d, input logic exp_v,
			input logic [WORD_WIDTH-1:0] exp_d);
		if (got_v !== exp_v)
			report_mismatch({name, " valid"}, got_v, exp_v);
		else if (exp_v && got_d !== exp_d)
			report_mismatch({name, " data"}, got_d, exp_d);
	endtask

	task automatic check_cycle();
		logic [NREQ-1:0] got_rdy;
		logic hit;
		logic ev;
		logic [WORD_WIDTH-1:0] ed;
		got_rdy = {gin_ready, gpr_single_ready, 1'b1, fin_ready, fpr_single_ready,
			itof_ready, fmul_ready, fadd_ready, 1'b1};
		// fdiv and ftoi have no ready output
		for (int r = 0; r < NREQ; r++) begin
			if (r != 0 && r != FIRST_GPR)
				check_ready(req_name[r], got_rdy[r], exp_rdy[r]);
		end
		check_bus("fpr_cdb", fpr_cdb_valid, fpr_cdb_tag, fpr_cdb_data,
			exp_v[0], exp_t[0], exp_d[0]);
		check_bus("gpr_cdb", gpr_cdb_valid, gpr_cdb_tag, gpr_cdb_data,
			exp_v[1], exp_t[1], exp_d[1]);
		// arch first then same-cycle bus hit then rob
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < N_READ; i++) begin
				hit = exp_v[c] && exp_t[c] == rd_at[c][i];
				ev = rd_av[c][i] || hit || rd_rv[c][i];
				ed = rd_av[c][i] ? rd_ad[c][i] : hit ? exp_d[c] : rd_rd[c][i];
				if (c == 0)
					check_read($sformatf("fpr_read[%0d]", i), fpr_read_valid[i],
						fpr_read_data[i], ev, ed);
				else
					check_read($sformatf("gpr_read[%0d]", i), gpr_read_valid[i],
						gpr_read_data[i], ev, ed);
			end
		end
	endtask

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= LIMIT) begin
				$display("timeout after %0d cycles, run did not finish", cycles);
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
		end
	end

	initial begin
		logic [23:0] row;
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < CAL; k++) begin
				cal_v[c][k] = 1'b0;
				cal_t[c][k] = '0;
				cal_d[c][k] = '0;
			end
		end
		n = 0;
		max_flight = 0;
		rst = 1'b1;
		apply_row('0);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// table then random traffic then idle cycles to drain the chains
		for (int k = 0; k < N_ROWS + N_RANDOM + FDIV_LATENCY + 2; k++) begin
			row = '0;
			if (k < N_ROWS) begin
				row = stim[k];
			end else if (k < N_ROWS + N_RANDOM) begin
				row[11:0] = 12'($random(seed)) & 12'($random(seed));
				row[23:12] = 12'($random(seed));
			end
			if (k == N_ROWS)
				max_flight = 0;
			@(posedge clk);
			apply_row(row);
			@(negedge clk);
			check_cycle();
			commit();
		end
		if (max_flight < 3) begin
			$display("random traffic never had more than %0d bookings in flight", max_flight);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* result_broadcast.f */
rtl/cdb_pkg.sv
rtl/slot_delay.sv
rtl/slot_segment.sv
rtl/cdb_drive.sv
rtl/operand_bypass.sv
rtl/fpr_wb_bus.sv
rtl/gpr_wb_bus.sv
rtl/result_broadcast.sv
sim/tb_result_broadcast.sv
